// File: source/sifh_pkg.sv
`default_nettype none

package sifh_pkg;

    // Pixel array and histogram geometry.
    localparam int PIX_NUM = 4;
    localparam int BIN_NUM = 16;
    localparam int PIX_W   = $clog2(PIX_NUM);
    localparam int BIN_W   = $clog2(BIN_NUM);
    localparam int CNT_W   = 8;
    localparam int ACQ_W   = 16;

    // Bin counters stop here instead of wrapping.
    localparam int CNT_MAX = 255;

    typedef logic [BIN_W-1:0]         bin_t;
    typedef logic [PIX_W-1:0]         pix_t;
    typedef logic [CNT_W-1:0]         cnt_t;
    typedef logic [ACQ_W-1:0]         acq_t;
    // Pixel 0 sits in the low nibble.
    typedef logic [PIX_NUM*BIN_W-1:0] peaks_t;

    // APB register map.
    localparam logic [7:0] ADDR_CTRL   = 8'h00;
    localparam logic [7:0] ADDR_ACQ    = 8'h04;
    localparam logic [7:0] ADDR_STATUS = 8'h08;
    localparam logic [7:0] ADDR_RESULT = 8'h0C;

    typedef enum logic [1:0] {
        IDLE,
        BUILD_HIS,
        FIND_PEAK,
        DONE
    } seq_state_t;

endpackage

`default_nettype wire

// File: source/sifh_ifs.sv
`default_nettype none

// Frame control between the register block and the sequencer.
interface sifh_ctrl_if
    import sifh_pkg::*;
();
    logic   start;
    logic   busy;
    logic   frame_done;
    acq_t   acq_num;
    peaks_t peaks;

    modport regs (
        output start,
        output acq_num,
        input  busy,
        input  frame_done,
        input  peaks
    );

    modport seq (
        input  start,
        input  acq_num,
        output busy,
        output frame_done,
        output peaks
    );
endinterface

// Increment port from the sequencer, read port from the peak finder.
interface sifh_hist_if
    import sifh_pkg::*;
();
    logic inc_en;
    pix_t inc_pix;
    bin_t inc_bin;
    logic rd_en;
    pix_t rd_pix;
    bin_t rd_bin;
    cnt_t rd_cnt;

    modport inc (output inc_en, output inc_pix, output inc_bin);
    modport rd  (output rd_en, output rd_pix, output rd_bin, input rd_cnt);
    modport mem (
        input  inc_en,
        input  inc_pix,
        input  inc_bin,
        input  rd_en,
        input  rd_pix,
        input  rd_bin,
        output rd_cnt
    );
endinterface

`default_nettype wire

// File: source/sifh_cfg_regs.sv
`default_nettype none

module sifh_cfg_regs
    import sifh_pkg::*;
(
    input  logic        clk,
    input  logic        res,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    sifh_ctrl_if.regs   ctrl
);

    logic   access;
    logic   wr_ok;
    logic   addr_ok;
    logic   ro_addr;
    logic   done_flag;
    peaks_t result;

    // No wait states, every access finishes in its enable cycle.
    assign access = psel && penable;
    assign pready = 1'b1;

    always_comb begin
        addr_ok = 1'b1;
        ro_addr = 1'b0;
        case (paddr)
            ADDR_CTRL, ADDR_ACQ: ro_addr = 1'b0;
            ADDR_STATUS, ADDR_RESULT: ro_addr = 1'b1;
            default: addr_ok = 1'b0;
        endcase
    end

    assign wr_ok   = access && pwrite && addr_ok && !ro_addr;
    assign pslverr = access && (!addr_ok || (pwrite && ro_addr));

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            ctrl.start   <= 1'b0;
            ctrl.acq_num <= '0;
        end else begin
            // A start while a frame runs is dropped here.
            ctrl.start <= wr_ok && (paddr == ADDR_CTRL) && pwdata[0] && !ctrl.busy;
            if (wr_ok && (paddr == ADDR_ACQ)) begin
                ctrl.acq_num <= pwdata[ACQ_W-1:0];
            end
        end
    end

    // Done and result hold until the next frame starts.
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            done_flag <= 1'b0;
            result    <= '0;
        end else if (ctrl.start) begin
            done_flag <= 1'b0;
        end else if (ctrl.frame_done) begin
            done_flag <= 1'b1;
            result    <= ctrl.peaks;
        end
    end

    always_comb begin
        prdata = '0;
        case (paddr)
            ADDR_ACQ:    prdata[ACQ_W-1:0] = ctrl.acq_num;
            ADDR_STATUS: prdata[1:0] = {done_flag, ctrl.busy};
            ADDR_RESULT: prdata[PIX_NUM*BIN_W-1:0] = result;
            default:     prdata = '0;
        endcase
    end

    // The busy flag comes from the sequencer a cycle behind the decode.
    a_no_start_busy: assert property (@(posedge clk) disable iff (!res)
        ctrl.start |-> !ctrl.busy);

endmodule

`default_nettype wire

// File: source/sifh_acq_seq.sv
`default_nettype none

module sifh_acq_seq
    import sifh_pkg::*;
(
    input  logic     clk,
    input  logic     res,
    input  logic     sample_valid,
    input  bin_t     sample_bin,
    output logic     sample_ready,
    sifh_ctrl_if.seq ctrl,
    sifh_hist_if.inc hist,
    output logic     scan_start,
    input  logic     scan_done,
    input  peaks_t   scan_peaks
);

    seq_state_t state;
    seq_state_t state_nxt;
    pix_t       pix_cnt;
    acq_t       acq_cnt;
    acq_t       acq_last;
    logic       accept;
    logic       pix_wrap;
    logic       acq_wrap;

    // A programmed count of zero still runs one acquisition.
    assign acq_last = (ctrl.acq_num == '0) ? '0 : ctrl.acq_num - acq_t'(1);

    assign sample_ready = (state == BUILD_HIS);
    assign accept       = sample_valid && sample_ready;
    assign pix_wrap     = (pix_cnt == pix_t'(PIX_NUM - 1));
    assign acq_wrap     = pix_wrap && (acq_cnt == acq_last);
    assign scan_start   = accept && acq_wrap;

    // Sample goes to the bin of the pixel whose turn it is.
    assign hist.inc_en  = accept;
    assign hist.inc_pix = pix_cnt;
    assign hist.inc_bin = sample_bin;

    assign ctrl.busy       = (state == BUILD_HIS) || (state == FIND_PEAK);
    assign ctrl.frame_done = (state == FIND_PEAK) && scan_done;
    assign ctrl.peaks      = scan_peaks;

    // Pixel counter carries into the acquisition counter.
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            pix_cnt <= '0;
            acq_cnt <= '0;
        end else if (ctrl.start) begin
            pix_cnt <= '0;
            acq_cnt <= '0;
        end else if (accept) begin
            if (!pix_wrap) begin
                pix_cnt <= pix_cnt + 1'b1;
            end else begin
                pix_cnt <= '0;
                if (!acq_wrap) begin
                    acq_cnt <= acq_cnt + 1'b1;
                end else begin
                    acq_cnt <= '0;
                end
            end
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE, DONE: if (ctrl.start) state_nxt = BUILD_HIS;
            BUILD_HIS:  if (scan_start) state_nxt = FIND_PEAK;
            FIND_PEAK:  if (scan_done) state_nxt = DONE;
            default:    state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // No increment lands past the last acquisition of the frame.
    a_inc_in_frame: assert property (@(posedge clk) disable iff (!res)
        hist.inc_en |-> (acq_cnt <= acq_last));

endmodule

`default_nettype wire

// File: source/sifh_hist_mem.sv
`default_nettype none

module sifh_hist_mem
    import sifh_pkg::*;
(
    input logic      clk,
    input logic      res,
    sifh_hist_if.mem hist
);

    // One saturating counter per pixel and bin.
    cnt_t cnt_mem [PIX_NUM][BIN_NUM];

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            for (int p = 0; p < PIX_NUM; p++) begin
                for (int b = 0; b < BIN_NUM; b++) begin
                    cnt_mem[p][b] <= '0;
                end
            end
        end else if (hist.inc_en) begin
            if (cnt_mem[hist.inc_pix][hist.inc_bin] != cnt_t'(CNT_MAX)) begin
                cnt_mem[hist.inc_pix][hist.inc_bin] <=
                    cnt_mem[hist.inc_pix][hist.inc_bin] + 1'b1;
            end
        end else if (hist.rd_en) begin
            // Cleared as it is read, so the next frame starts empty.
            cnt_mem[hist.rd_pix][hist.rd_bin] <= '0;
        end
    end

    // Read data lands one cycle after the request.
    always_ff @(posedge clk) begin
        if (hist.rd_en) begin
            hist.rd_cnt <= cnt_mem[hist.rd_pix][hist.rd_bin];
        end
    end

    // Sequencer and peak finder share the counters only through the frame state.
    a_inc_rd_excl: assert property (@(posedge clk) disable iff (!res)
        !(hist.inc_en && hist.rd_en));

endmodule

`default_nettype wire

// File: source/sifh_peak_find.sv
`default_nettype none

module sifh_peak_find
    import sifh_pkg::*;
(
    input  logic     clk,
    input  logic     res,
    input  logic     start,
    sifh_hist_if.rd  hist,
    output logic     done,
    output peaks_t   peaks
);

    localparam int IDX_W = PIX_W + BIN_W;

    logic [IDX_W-1:0] rd_idx;
    logic             active;
    logic             cmp_vld;
    pix_t             cmp_pix;
    bin_t             cmp_bin;
    cnt_t             max_cnt;
    bin_t             max_bin;
    logic             take;
    logic             last_bin;

    // Walks pixel-major, bin-minor.
    assign hist.rd_en  = active;
    assign hist.rd_pix = rd_idx[IDX_W-1 -: PIX_W];
    assign hist.rd_bin = rd_idx[BIN_W-1:0];

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            active <= 1'b0;
            rd_idx <= '0;
        end else if (start && !active) begin
            active <= 1'b1;
            rd_idx <= '0;
        end else if (active) begin
            rd_idx <= rd_idx + 1'b1;
            if (&rd_idx) begin
                active <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            cmp_vld <= 1'b0;
        end else begin
            cmp_vld <= active;
        end
    end

    // Address of the count that is in flight.
    always_ff @(posedge clk) begin
        cmp_pix <= hist.rd_pix;
        cmp_bin <= hist.rd_bin;
    end

    // Strictly greater only, so on a tie the lower bin stays.
    assign take     = (cmp_bin == '0) || (hist.rd_cnt > max_cnt);
    assign last_bin = (cmp_bin == bin_t'(BIN_NUM - 1));

    always_ff @(posedge clk) begin
        if (cmp_vld && take) begin
            max_cnt <= hist.rd_cnt;
            max_bin <= cmp_bin;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            peaks <= '0;
            done  <= 1'b0;
        end else begin
            done <= cmp_vld && last_bin && (cmp_pix == pix_t'(PIX_NUM - 1));
            if (cmp_vld && last_bin) begin
                peaks[cmp_pix*BIN_W +: BIN_W] <= take ? cmp_bin : max_bin;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/sifh_top.sv
`default_nettype none

module sifh_top
    import sifh_pkg::*;
(
    input  logic        clk,
    input  logic        res,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    input  logic        sample_valid,
    input  bin_t        sample_bin,
    output logic        sample_ready
);

    logic   scan_start;
    logic   scan_done;
    peaks_t scan_peaks;

    sifh_ctrl_if ctrl_if ();
    sifh_hist_if hist_if ();

    sifh_cfg_regs regs0 (
        .clk     (clk),
        .res     (res),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .ctrl    (ctrl_if.regs)
    );

    sifh_acq_seq seq0 (
        .clk          (clk),
        .res          (res),
        .sample_valid (sample_valid),
        .sample_bin   (sample_bin),
        .sample_ready (sample_ready),
        .ctrl         (ctrl_if.seq),
        .hist         (hist_if.inc),
        .scan_start   (scan_start),
        .scan_done    (scan_done),
        .scan_peaks   (scan_peaks)
    );

    sifh_hist_mem mem0 (
        .clk  (clk),
        .res  (res),
        .hist (hist_if.mem)
    );

    sifh_peak_find find0 (
        .clk   (clk),
        .res   (res),
        .start (scan_start),
        .hist  (hist_if.rd),
        .done  (scan_done),
        .peaks (scan_peaks)
    );

endmodule

`default_nettype wire

// File: verification/sifh_tb.sv
`default_nettype none

module sifh_tb
    import sifh_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MODE_RAND  = 0;
    localparam int MODE_TIE   = 1;
    localparam int MODE_SAT   = 2;
    localparam int SAMPLE_TMO = 20;
    localparam int POLL_TMO   = 60;

    logic        clk;
    logic        res;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        sample_valid;
    bin_t        sample_bin;
    logic        sample_ready;

    integer      seed = 32'h2014_dc1e;
    int          err_cnt = 0;
    int          tmo_cnt = 0;
    int          hist_ref [PIX_NUM][BIN_NUM];
    pix_t        tb_pix;
    peaks_t      exp_q [$];
    peaks_t      got_q [$];

    sifh_top dut0 (
        .clk          (clk),
        .res          (res),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .sample_valid (sample_valid),
        .sample_bin   (sample_bin),
        .sample_ready (sample_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic int sat_cnt(input int n);
        return (n > CNT_MAX) ? CNT_MAX : n;
    endfunction

    // Lowest bin with the highest saturated count, per pixel.
    function automatic peaks_t ref_peaks();
        peaks_t pk;
        int     best;
        pk = '0;
        for (int p = 0; p < PIX_NUM; p++) begin
            best = 0;
            for (int b = 1; b < BIN_NUM; b++) begin
                if (sat_cnt(hist_ref[p][b]) > sat_cnt(hist_ref[p][best])) begin
                    best = b;
                end
            end
            pk[p*BIN_W +: BIN_W] = bin_t'(best);
        end
        return pk;
    endfunction

    function automatic bin_t pick_bin(input int mode, input int p, input int a);
        logic [15:0] row;
        case (mode)
            MODE_TIE: begin
                // Each pixel gets two bins twice, one nibble per acquisition.
                case (p)
                    0:       row = 16'h3939;
                    1:       row = 16'hE55E;
                    2:       row = 16'h0FF0;
                    default: row = 16'h77CC;
                endcase
                return row[(a % 4)*4 +: 4];
            end
            MODE_SAT: begin
                case (p)
                    0:       return (a % 20 == 0) ? 4'd2 : 4'd11;
                    1:       return (a < 270) ? 4'd13 : 4'd1;
                    2:       return (a % 2 == 1) ? 4'd6 : 4'd9;
                    default: return (a % 3 == 0) ? 4'd4 : 4'd8;
                endcase
            end
            default: return bin_t'($random(seed));
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        err = pslverr;
        check_value("pready", 32'(pready), 32'h1);
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        data = prdata;
        err  = pslverr;
        check_value("pready", 32'(pready), 32'h1);
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    // Holds the sample until the DUT takes it; only taken samples count.
    task automatic send_sample(input bin_t bin);
        int   waited;
        logic taken;
        waited = 0;
        taken  = 1'b0;
        while (!taken && waited < SAMPLE_TMO) begin
            @(posedge clk);
            sample_valid <= 1'b1;
            sample_bin   <= bin;
            @(negedge clk);
            taken = sample_ready;
            waited++;
        end
        if (taken) begin
            hist_ref[tb_pix][bin]++;
            tb_pix++;
        end else begin
            $display("Timeout: sample for pixel %0d was never accepted", tb_pix);
            tmo_cnt++;
        end
    endtask

    // Samples offered while the DUT is not in its build phase.
    task automatic drive_unready(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk);
            sample_valid <= 1'b1;
            sample_bin   <= bin_t'($random(seed));
            @(negedge clk);
            check_value("sample_ready", 32'(sample_ready), 32'h0);
        end
        @(posedge clk);
        sample_valid <= 1'b0;
    endtask

    task automatic wait_done();
        logic [31:0] st;
        logic        err;
        int          polls;
        polls = 0;
        st    = '0;
        while (!st[1] && polls < POLL_TMO) begin
            apb_read(ADDR_STATUS, st, err);
            polls++;
        end
        if (!st[1]) begin
            $display("Timeout: done flag not set after %0d STATUS polls", polls);
            tmo_cnt++;
        end else begin
            check_value("STATUS", st, 32'h2);
            check_value("pslverr", 32'(err), 32'h0);
        end
    endtask

    task automatic run_frame(input int mode, input int acq_reg, input bit busy_start);
        logic [31:0] rd;
        logic        err;
        int          acqs;
        acqs = (acq_reg == 0) ? 1 : acq_reg;
        apb_write(ADDR_ACQ, 32'(acq_reg), err);
        apb_write(ADDR_CTRL, 32'h1, err);
        for (int p = 0; p < PIX_NUM; p++) begin
            for (int b = 0; b < BIN_NUM; b++) begin
                hist_ref[p][b] = 0;
            end
        end
        tb_pix = '0;
        for (int a = 0; a < acqs; a++) begin
            if (busy_start && a == acqs / 2) begin
                @(posedge clk);
                sample_valid <= 1'b0;
                // A second start here must leave the counters running.
                apb_write(ADDR_CTRL, 32'h1, err);
                apb_read(ADDR_STATUS, rd, err);
                check_value("STATUS", rd, 32'h1);
            end
            for (int p = 0; p < PIX_NUM; p++) begin
                send_sample(pick_bin(mode, p, a));
            end
        end
        drive_unready(3);
        wait_done();
        apb_read(ADDR_RESULT, rd, err);
        check_value("pslverr", 32'(err), 32'h0);
        exp_q.push_back(ref_peaks());
        got_q.push_back(rd[PIX_NUM*BIN_W-1:0]);
    endtask

    // Compares each RESULT read with the reference peaks.
    always @(posedge clk) begin : result_check
        peaks_t exp_v;
        peaks_t got_v;
        while (exp_q.size() > 0) begin
            exp_v = exp_q.pop_front();
            got_v = got_q.pop_front();
            assert (got_v === exp_v) else begin
                $display("** Error: RESULT got 0x%h expected 0x%h", got_v, exp_v);
                err_cnt++;
            end
        end
    end

    initial begin : main
        logic [31:0] rd;
        logic        err;
        res          = 1'b0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        sample_valid = 1'b0;
        sample_bin   = '0;
        repeat (4) @(posedge clk);
        res <= 1'b1;

        // Reset values and bus errors.
        apb_read(ADDR_STATUS, rd, err);
        check_value("STATUS", rd, 32'h0);
        apb_read(ADDR_RESULT, rd, err);
        check_value("RESULT", rd, 32'h0);
        @(negedge clk);
        check_value("sample_ready", 32'(sample_ready), 32'h0);
        apb_read(8'h10, rd, err);
        check_value("pslverr", 32'(err), 32'h1);
        apb_write(ADDR_STATUS, 32'h1, err);
        check_value("pslverr", 32'(err), 32'h1);
        drive_unready(4);

        run_frame(MODE_RAND, 10, 1'b0);
        run_frame(MODE_TIE, 4, 1'b0);
        run_frame(MODE_SAT, 300, 1'b0);
        // Leftover counts from the saturated frame would win here.
        run_frame(MODE_RAND, 10, 1'b1);
        run_frame(MODE_RAND, 0, 1'b0);

        repeat (2) @(posedge clk);
        $display("Errors: %0d wrong values, %0d timeouts", err_cnt, tmo_cnt);
        if (err_cnt == 0 && tmo_cnt == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
source/sifh_pkg.sv
source/sifh_ifs.sv
source/sifh_cfg_regs.sv
source/sifh_acq_seq.sv
source/sifh_hist_mem.sv
source/sifh_peak_find.sv
source/sifh_top.sv
verification/sifh_tb.sv
